// File: cpu_timing_pkg.sv
// phase and stall types for the E/Q timing; cen must be a strobe, not tied high, or E/Q fall out of step
package cpu_timing_pkg;

    // phase counter, one step per cen strobe
    typedef logic [1:0] phase_t;

    // lost enable slots waiting to be recovered
    typedef logic [3:0] miss_t;

    // phase values that open the two CPU enables
    localparam phase_t phase_e = 2'd0;
    localparam phase_t phase_q = 2'd2;

    // miss count saturates here, longer stalls are not recovered in full
    localparam miss_t miss_max = 4'd15;

    // catch-up jump after a stall
    // with this at 0 the sequence just resumes where it stopped
    localparam bit recovery_en = 1'b1;

    // why the CPU is currently held
    typedef enum logic [1:0] {
        run,        // enables flow
        rom_wait,   // rom data not ready yet
        bus_wait    // shared bus held by another device
    } wait_state_t;

endpackage

// File: cpu_bus_pkg.sv
// 6809 bus widths; the work ram decodes only the low address bits, so it mirrors across the map
package cpu_bus_pkg;

    // cpu address and data
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // work ram geometry
    localparam int ram_aw = 12;
    localparam int ram_depth = 1 << ram_aw;

    typedef logic [ram_aw-1:0] ram_addr_t;

endpackage

// File: cpu_phase_if.sv
// gate and enable signals between the stall control and the phase datapath; all levels sampled on clk
`timescale 1ns/1ps

interface cpu_phase_if;

    logic gate;      // high when the cpu may run this cycle
    logic cen_e;     // E phase enable, one clk wide
    logic cen_q;     // Q phase enable, one clk wide
    logic catchup;   // missed slots pending, jump instead of step
    logic miss_inc;  // one more slot lost to a stall

    // stall decision
    modport ctrl (
        output gate
    );

    // phase counter and enable outputs
    modport phase (
        input  gate,
        input  catchup,
        output cen_e,
        output cen_q,
        output miss_inc
    );

    // bookkeeping of lost slots
    modport miss (
        input  gate,
        input  miss_inc,
        output catchup
    );

endinterface

// File: bus_wait_ctrl.sv
// gate follows rom_cs/rom_ok/dev_busy in the same cycle; rom_ok is expected to stay high once given
`timescale 1ns/1ps

module bus_wait_ctrl (
    input  logic      clk,
    input  logic      rstn,
    input  logic      rom_cs,
    input  logic      rom_ok,
    input  logic      dev_busy,
    cpu_phase_if.ctrl bus
);
    import cpu_timing_pkg::*;

    wait_state_t state;      // cause of the stall seen last cycle
    wait_state_t state_nxt;
    logic        rom_stall;

    assign rom_stall = rom_cs & ~rom_ok;  // rom selected but sdram data late

    // rom wait wins over a busy bus
    always_comb begin
        if (rom_stall) begin
            state_nxt = rom_wait;
        end else if (dev_busy) begin
            state_nxt = bus_wait;
        end else begin
            state_nxt = run;
        end
    end

    // purely combinational so the stall hits the current cen
    assign bus.gate = (state_nxt == run);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= run;
        end else begin
            state <= state_nxt;
        end
    end

    // an open gate is never recorded as a rom stall
    a_gate_not_rom: assert property (
        @(posedge clk) disable iff (!rstn)
        bus.gate |=> (state != rom_wait)
    );

    // bus_wait only follows a cycle with dev_busy set
    a_bus_wait_entry: assert property (
        @(posedge clk) disable iff (!rstn)
        (state != bus_wait) ##1 (state == bus_wait) |-> $past(dev_busy)
    );

endmodule

// File: miss_counter.sv
// counts enable slots lost while gated, up to miss_max; slots beyond that are simply dropped
`timescale 1ns/1ps

module miss_counter (
    input  logic      clk,
    input  logic      rstn,
    input  logic      cen,
    cpu_phase_if.miss bus
);
    import cpu_timing_pkg::*;

    miss_t count;
    logic  jump;

    // recovery only while something is owed
    assign bus.catchup = recovery_en && (count != '0);

    // same condition phase_gen uses to take the half-cycle jump
    assign jump = cen & bus.gate & bus.catchup;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (jump) begin
            count <= count - 4'd1;          // one slot paid back
        end else if (bus.miss_inc && (count != miss_max)) begin
            count <= count + 4'd1;
        end
    end

    // no wrap in either direction
    a_no_wrap_up: assert property (
        @(posedge clk) disable iff (!rstn)
        (count == miss_max) |=> (count != '0)
    );

    a_no_wrap_down: assert property (
        @(posedge clk) disable iff (!rstn)
        (count == '0) |=> (count != miss_max)
    );

endmodule

// File: phase_gen.sv
// divides cen by four into E and Q; enables are combinational from cen and only valid while cen pulses
`timescale 1ns/1ps

module phase_gen (
    input  logic       clk,
    input  logic       rstn,
    input  logic       cen,
    cpu_phase_if.phase bus
);
    import cpu_timing_pkg::*;

    phase_t phase;
    logic   prev_none;  // last cen gave neither E nor Q
    logic   en_now;

    // no extra latency from cen
    assign bus.cen_e = cen & bus.gate & (phase == phase_e);
    assign bus.cen_q = cen & bus.gate & (phase == phase_q);
    assign en_now    = bus.cen_e | bus.cen_q;

    // a slot counts as lost only after two quiet strobes in a row
    assign bus.miss_inc = cen & ~bus.gate & ~en_now & prev_none;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase     <= phase_e;
            prev_none <= 1'b0;
        end else if (cen) begin
            prev_none <= ~en_now;
            if (bus.gate) begin
                if (bus.catchup) begin
                    phase <= {~phase[1], 1'b0}; // skip to start of other half
                end else begin
                    phase <= phase + 2'd1;
                end
            end
            // gated: phase holds
        end
    end

    a_e_q_exclusive: assert property (
        @(posedge clk) disable iff (!rstn)
        !(bus.cen_e && bus.cen_q)
    );

endmodule

// File: work_ram.sv
// byte ram clocked on Q; read data is the old byte on a write and appears the clk after cen_q
`timescale 1ns/1ps

module work_ram (
    input  logic                  clk,
    input  logic                  cen_q,
    input  logic                  we,
    input  cpu_bus_pkg::ram_addr_t addr,
    input  cpu_bus_pkg::data_t    din,
    output cpu_bus_pkg::data_t    dout
);
    import cpu_bus_pkg::*;

    data_t mem [0:ram_depth-1];

    // read before write on the same Q
    always_ff @(posedge clk) begin
        if (cen_q) begin
            dout <= mem[addr];
            if (we) begin
                mem[addr] <= din;
            end
        end
    end

endmodule

// File: cpu_bus_sys.sv
// bus timing and work ram for a 6809 core kept outside; ram decodes only the low ram_aw address bits
`timescale 1ns/1ps

module cpu_bus_sys (
    input  logic               clk,
    input  logic               rstn,
    input  logic               cen,       // cpu input clock strobe
    input  logic               rom_cs,
    input  logic               rom_ok,
    input  logic               dev_busy,
    input  logic               ram_cs,
    input  logic               rnw,
    input  cpu_bus_pkg::addr_t addr,
    input  cpu_bus_pkg::data_t cpu_dout,
    output logic               cen_e,
    output logic               cen_q,
    output logic               cpu_cen,   // quarter of cen
    output cpu_bus_pkg::data_t ram_dout
);
    import cpu_bus_pkg::*;

    cpu_phase_if phase_bus ();

    logic      ram_we;
    ram_addr_t ram_addr;

    assign ram_we   = ram_cs & ~rnw;
    assign ram_addr = addr[ram_aw-1:0];

    assign cen_e   = phase_bus.cen_e;
    assign cen_q   = phase_bus.cen_q;
    assign cpu_cen = phase_bus.cen_q;

    bus_wait_ctrl u_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .dev_busy (dev_busy),
        .bus      (phase_bus.ctrl)
    );

    miss_counter u_miss (
        .clk  (clk),
        .rstn (rstn),
        .cen  (cen),
        .bus  (phase_bus.miss)
    );

    phase_gen u_phase (
        .clk  (clk),
        .rstn (rstn),
        .cen  (cen),
        .bus  (phase_bus.phase)
    );

    work_ram u_ram (
        .clk   (clk),
        .cen_q (phase_bus.cen_q),  // Q edge, not E
        .we    (ram_we),
        .addr  (ram_addr),
        .din   (cpu_dout),
        .dout  (ram_dout)
    );

endmodule

// File: tb_cpu_bus_sys.sv
// stimulus is pseudo-random from a fixed seed; ram checks reach only the 16 low words driven here
`timescale 1ns/1ps

module tb_cpu_bus_sys;
    import cpu_bus_pkg::*;

    localparam int free_len   = 200;   // cycles without any stall
    localparam int hold_len   = 40;    // fixed rom and bus stalls
    localparam int gap_len    = 20;
    localparam int n_bursts   = 48;
    localparam int burst_max  = 170;   // longest run plus stall of one burst
    localparam int tail_len   = 10;
    localparam int total_len  = 3 + free_len + 2 * (hold_len + gap_len)
                                + n_bursts * burst_max + tail_len;
    localparam int timeout_cycles = 4 * total_len;

    logic  clk      = 1'b0;
    logic  rstn     = 1'b0;
    logic  cen      = 1'b0;
    logic  rom_cs   = 1'b0;
    logic  rom_ok   = 1'b1;
    logic  dev_busy = 1'b0;
    logic  ram_cs   = 1'b0;
    logic  rnw      = 1'b1;
    addr_t addr     = '0;
    data_t cpu_dout = '0;

    logic  cen_e;
    logic  cen_q;
    logic  cpu_cen;
    data_t ram_dout;

    logic [31:0] lfsr_state = 32'h6a73;

    // reference state
    int    ref_phase;
    int    ref_miss;
    logic  ref_prev_none;
    data_t ref_mem [0:(1 << ram_aw)-1];
    bit    written [0:(1 << ram_aw)-1];
    logic  pend_chk;
    data_t pend_data;

    // checker bookkeeping
    logic [1:0] exp_en;
    logic       gate_exp;
    ram_addr_t  ra;
    int         last_en;        // 0 none, 1 E, 2 Q
    int         strobe_gap;
    logic       seen_en;
    logic       sat_seen = 1'b0;
    logic       free_run = 1'b0;
    int         errors = 0;
    int         cycles_checked = 0;
    int         reads_checked = 0;
    int         cycle_cnt = 0;

    // burst parameters
    logic [31:0] rl;
    logic [31:0] sk;
    logic [31:0] sl;
    logic [31:0] kd;
    int          stall_len;

    cpu_bus_sys i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .cen      (cen),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .dev_busy (dev_busy),
        .ram_cs   (ram_cs),
        .rnw      (rnw),
        .addr     (addr),
        .cpu_dout (cpu_dout),
        .cen_e    (cen_e),
        .cen_q    (cen_q),
        .cpu_cen  (cpu_cen),
        .ram_dout (ram_dout)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // one cen slot of the E/Q rules, returns {cen_e, cen_q}
    function automatic logic [1:0] model_step(input logic c, input logic g);
        logic e;
        logic q;
        e = c && g && (ref_phase == 0);
        q = c && g && (ref_phase == 2);
        if (c) begin
            if (g && ref_miss != 0) begin
                ref_phase = (ref_phase < 2) ? 2 : 0;  // jump to other half
                ref_miss  = ref_miss - 1;
            end else if (g) begin
                ref_phase = (ref_phase + 1) % 4;
            end else if (ref_prev_none && ref_miss != 15) begin
                ref_miss = ref_miss + 1;
            end
            ref_prev_none = !(e || q);
        end
        return {e, q};
    endfunction

    task automatic drive_cycle(input logic rom_stall, input logic busy);
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] d;
        @(posedge clk);
        r  = take_bits(5);
        hi = take_bits(4);
        lo = take_bits(4);
        d  = take_bits(8);
        cen      <= r[0];
        rom_cs   <= rom_stall | r[1];
        rom_ok   <= rom_stall ? 1'b0 : (r[1] | r[4]);  // rom_ok alone never stalls
        dev_busy <= busy;
        ram_cs   <= r[2];
        rnw      <= r[3];
        addr     <= {hi[3:0], 8'h00, lo[3:0]};          // high nibble hits the mirror
        cpu_dout <= d[7:0];
    endtask

    // compare at the falling edge, inputs and outputs settled
    always @(negedge clk) begin
        if (rstn !== 1'b1) begin
            ref_phase     = 0;
            ref_miss      = 0;
            ref_prev_none = 1'b0;
            pend_chk      = 1'b0;
            last_en       = 0;
            strobe_gap    = 0;
            seen_en       = 1'b0;
        end else begin
            cycles_checked++;
            if (pend_chk) begin
                reads_checked++;
                assert (ram_dout === pend_data) else begin
                    errors++;
                    $display("mismatch ram_dout: got %h expected %h", ram_dout, pend_data);
                end
            end
            pend_chk = 1'b0;

            gate_exp = !(rom_cs && !rom_ok) && !dev_busy;
            exp_en   = model_step(cen, gate_exp);
            if (ref_miss == 15) sat_seen = 1'b1;

            assert (cen_e === exp_en[1]) else begin
                errors++;
                $display("mismatch cen_e: got %h expected %h at cycle %0d",
                         cen_e, exp_en[1], cycles_checked);
            end
            assert (cen_q === exp_en[0]) else begin
                errors++;
                $display("mismatch cen_q: got %h expected %h at cycle %0d",
                         cen_q, exp_en[0], cycles_checked);
            end
            assert (cpu_cen === exp_en[0]) else begin
                errors++;
                $display("mismatch cpu_cen: got %h expected %h at cycle %0d",
                         cpu_cen, exp_en[0], cycles_checked);
            end
            if (!gate_exp) begin
                assert (!cen_e && !cen_q) else begin
                    errors++;
                    $display("enable pulse while the bus was stalled, cycle %0d", cycles_checked);
                end
            end

            // E and Q must take turns
            if (cen_e === 1'b1) begin
                assert (last_en != 1) else begin
                    errors++;
                    $display("two E enables without a Q in between");
                end
                last_en = 1;
            end else if (cen_q === 1'b1) begin
                assert (last_en != 2) else begin
                    errors++;
                    $display("two Q enables without an E in between");
                end
                last_en = 2;
            end

            if (free_run && cen) begin
                strobe_gap++;
                if (cen_e === 1'b1 || cen_q === 1'b1) begin
                    if (seen_en) begin
                        assert (strobe_gap == 2) else begin
                            errors++;
                            $display("free running enables %0d cen strobes apart, not 2",
                                     strobe_gap);
                        end
                    end
                    strobe_gap = 0;
                    seen_en    = 1'b1;
                end
            end

            // ram model, read-first on the expected Q
            if (exp_en[0]) begin
                ra = addr[ram_aw-1:0];
                if (written[ra]) begin
                    pend_chk  = 1'b1;
                    pend_data = ref_mem[ra];
                end
                if (ram_cs && !rnw) begin
                    ref_mem[ra] = cpu_dout;
                    written[ra] = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not end within %0d cycles", timeout_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        free_run = 1'b1;
        repeat (free_len) drive_cycle(1'b0, 1'b0);
        free_run = 1'b0;

        repeat (hold_len) drive_cycle(1'b1, 1'b0);  // rom data late
        repeat (gap_len) drive_cycle(1'b0, 1'b0);
        repeat (hold_len) drive_cycle(1'b0, 1'b1);  // bus busy
        repeat (gap_len) drive_cycle(1'b0, 1'b0);

        // random runs and stalls, one in eight long enough to saturate
        for (int b = 0; b < n_bursts; b++) begin
            rl = take_bits(5);
            sk = take_bits(3);
            sl = take_bits(5);
            kd = take_bits(2);
            stall_len = (sk == 0) ? 100 + sl : 1 + sl;
            repeat (4 + rl) drive_cycle(1'b0, 1'b0);
            repeat (stall_len) drive_cycle(kd != 2, kd >= 2);
        end

        repeat (tail_len) drive_cycle(1'b0, 1'b0);
        repeat (2) @(posedge clk);

        assert (sat_seen) else begin
            errors++;
            $display("miss count never reached saturation during the long stalls");
        end
        $display("cycles checked %0d, ram reads checked %0d, errors %0d",
                 cycles_checked, reads_checked, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
cpu_timing_pkg.sv
cpu_bus_pkg.sv
cpu_phase_if.sv
bus_wait_ctrl.sv
miss_counter.sv
phase_gen.sv
work_ram.sv
cpu_bus_sys.sv
tb_cpu_bus_sys.sv

// File: Makefile
# Verilator build and run for the cpu bus timing testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_bus_sys
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
